/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_l2_top
	./obj_dir/Vtb_l2_top | tee /dev/stderr | grep -q "Verification passed"

clean:
	rm -rf obj_dir

/* files.f */
l2_pkg.sv
l2_mem_if.sv
sp_bram.sv
plru_tree.sv
wb_buffer.sv
l2_cache.sv
l2_top.sv
tb_l2_top.sv

/* l2_cache.sv */
// Set-associative write-back cache controller
// Blocking, one request at a time. Hits answer two cycles after acceptance, misses
// write back a dirty victim first and then fetch the line through the memory channel.
// A flush walk invalidates all sets after reset and on flush_i, without write-back.

`timescale 1ns/1ps

module l2_cache #(
  parameter int CACHE_SIZE = l2_pkg::CACHE_SIZE,
  parameter int BLK_SIZE   = l2_pkg::BLK_SIZE,
  parameter int XLEN       = l2_pkg::XLEN,
  parameter int NUM_WAY    = l2_pkg::NUM_WAY
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  logic [XLEN-1:0]      req_addr_i,
  input  logic                 req_we_i,
  input  l2_pkg::access_size_e req_size_i,
  input  logic [XLEN-1:0]      req_wdata_i,
  output logic                 res_valid_o,
  input  logic                 res_ready_i,
  output logic [XLEN-1:0]      res_rdata_o,
  l2_mem_if.ctrl               mem
);

  localparam int NUM_SET = CACHE_SIZE / (BLK_SIZE / 8) / NUM_WAY;
  localparam int IDX_W   = (NUM_SET > 1) ? $clog2(NUM_SET) : 1;
  localparam int OFF_W   = $clog2(BLK_SIZE / 8);
  localparam int TAG_W   = XLEN - IDX_W - OFF_W;

  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
  } tag_entry_t;

  typedef enum logic [2:0] {
    ST_FLUSH, ST_IDLE, ST_LOOKUP, ST_WB, ST_FILL, ST_UPDATE, ST_RESP
  } state_e;

  state_e                 state_q;
  logic [IDX_W-1:0]       flush_idx_q;
  logic                   flush_pend_q;
  logic                   rd_valid_q;
  logic                   fill_sent_q;
  logic [NUM_WAY-1:0]     dirty_q [NUM_SET];
  logic [XLEN-1:0]        addr_q;
  logic                   we_q;
  l2_pkg::access_size_e   size_q;
  logic [XLEN-1:0]        wdata_q;
  logic [BLK_SIZE-1:0]    line_q;
  logic [XLEN-1:0]        res_rdata_q;

  logic [IDX_W-1:0]       req_idx;
  logic [IDX_W-1:0]       arr_idx;
  logic [TAG_W-1:0]       req_tag;
  tag_entry_t             tag_rd [NUM_WAY];
  tag_entry_t             tag_wdata;
  logic [BLK_SIZE-1:0]    data_rd [NUM_WAY];
  logic [NUM_WAY-1:0]     tag_we;
  logic [NUM_WAY-1:0]     data_we;
  logic [NUM_WAY-1:0]     hit_vec;
  logic [NUM_WAY-1:0]     victim_way;
  logic [TAG_W-1:0]       victim_tag;
  logic [BLK_SIZE-1:0]    hit_line;
  logic [BLK_SIZE-1:0]    victim_line;
  logic [BLK_SIZE-1:0]    base_line;
  logic [BLK_SIZE-1:0]    merged_line;
  logic [BLK_SIZE-1:0]    resp_line;
  logic                   hit;
  logic                   lk_done;
  logic                   hit_write;
  logic                   fill_write;
  logic                   victim_dirty;

  assign req_idx = addr_q[OFF_W +: IDX_W];
  assign req_tag = addr_q[XLEN-1 -: TAG_W];
  assign arr_idx = (state_q == ST_FLUSH) ? flush_idx_q : req_idx;

  // ====================
  // Lookup
  // ====================

  // Compare all ways at once and pick out the victim line
  always_comb begin
    hit_vec     = '0;
    hit_line    = '0;
    victim_line = '0;
    victim_tag  = '0;
    for (int w = 0; w < NUM_WAY; w++) begin
      hit_vec[w] = tag_rd[w].valid && (tag_rd[w].tag == req_tag);
      if (hit_vec[w]) hit_line = data_rd[w];
      if (victim_way[w]) begin
        victim_line = data_rd[w];
        victim_tag  = tag_rd[w].tag;
      end
    end
  end

  assign hit          = |hit_vec;
  assign victim_dirty = |(dirty_q[req_idx] & victim_way);
  // Second lookup cycle, arrays hold the request's set
  assign lk_done      = (state_q == ST_LOOKUP) && rd_valid_q;
  assign hit_write    = lk_done && hit && we_q;
  assign fill_write   = (state_q == ST_FILL) && mem.rsp_valid;

  // Write data goes into the hit line or the incoming fill
  always_comb begin
    base_line   = (state_q == ST_FILL) ? mem.rsp_rdata : hit_line;
    merged_line = base_line;
    if (we_q) begin
      case (size_q)
        l2_pkg::SZ_BYTE: merged_line[addr_q[OFF_W-1:0]*8 +: 8]   = wdata_q[7:0];
        l2_pkg::SZ_HALF: merged_line[addr_q[OFF_W-1:1]*16 +: 16] = wdata_q[15:0];
        default:         merged_line[addr_q[OFF_W-1:2]*32 +: 32] = wdata_q[31:0];
      endcase
    end
  end

  assign resp_line = (state_q == ST_UPDATE) ? line_q : hit_line;

  // ====================
  // Arrays
  // ====================

  always_comb begin
    for (int w = 0; w < NUM_WAY; w++) begin
      tag_we[w]  = (state_q == ST_FLUSH) || (fill_write && victim_way[w]);
      data_we[w] = (hit_write && hit_vec[w]) || (fill_write && victim_way[w]);
    end
  end

  assign tag_wdata.valid = (state_q != ST_FLUSH);
  assign tag_wdata.tag   = req_tag;

  for (genvar w = 0; w < NUM_WAY; w++) begin : g_way
    sp_bram #(
      .entry_t (logic [BLK_SIZE-1:0]),
      .DEPTH   (NUM_SET)
    ) u_data (
      .clk_i   (clk_i),
      .addr_i  (arr_idx),
      .we_i    (data_we[w]),
      .wdata_i (merged_line),
      .rdata_o (data_rd[w])
    );

    sp_bram #(
      .entry_t (tag_entry_t),
      .DEPTH   (NUM_SET)
    ) u_tag (
      .clk_i   (clk_i),
      .addr_i  (arr_idx),
      .we_i    (tag_we[w]),
      .wdata_i (tag_wdata),
      .rdata_o (tag_rd[w])
    );
  end

  plru_tree #(
    .NUM_WAY      (NUM_WAY),
    .NUM_SET      (NUM_SET)
  ) u_plru (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .idx_i        (arr_idx),
    .touch_i      ((lk_done && hit) || fill_write),
    .touch_way_i  ((state_q == ST_FILL) ? victim_way : hit_vec),
    .clear_i      (state_q == ST_FLUSH),
    .victim_way_o (victim_way)
  );

  // ====================
  // Memory and requester sides
  // ====================

  assign mem.req_valid = (state_q == ST_WB) || ((state_q == ST_FILL) && !fill_sent_q);
  assign mem.req_we    = (state_q == ST_WB);
  assign mem.req_addr  = (state_q == ST_WB) ? {victim_tag, req_idx, {OFF_W{1'b0}}}
                                            : {addr_q[XLEN-1:OFF_W], {OFF_W{1'b0}}};
  assign mem.req_wdata = victim_line;

  assign req_ready_o = (state_q == ST_IDLE) && !flush_pend_q;
  assign res_valid_o = (state_q == ST_RESP);
  assign res_rdata_o = res_rdata_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q      <= ST_FLUSH;
      flush_idx_q  <= '0;
      flush_pend_q <= 1'b0;
      rd_valid_q   <= 1'b0;
      fill_sent_q  <= 1'b0;
      for (int s = 0; s < NUM_SET; s++) dirty_q[s] <= '0;
    end else begin
      // Flush waits for the request in flight
      if (flush_i) flush_pend_q <= 1'b1;
      case (state_q)
        ST_FLUSH: begin
          dirty_q[flush_idx_q] <= '0;
          flush_idx_q          <= flush_idx_q + 1'b1;
          if (flush_idx_q == IDX_W'(NUM_SET - 1)) begin
            flush_idx_q <= '0;
            state_q     <= ST_IDLE;
          end
        end
        ST_IDLE: begin
          if (req_valid_i && req_ready_o) begin
            state_q    <= ST_LOOKUP;
            rd_valid_q <= 1'b0;
          end else if (flush_i || flush_pend_q) begin
            state_q      <= ST_FLUSH;
            flush_pend_q <= 1'b0;
          end
        end
        ST_LOOKUP: begin
          rd_valid_q  <= 1'b1;
          fill_sent_q <= 1'b0;
          if (rd_valid_q) begin
            if (hit) begin
              state_q <= ST_RESP;
              if (we_q) dirty_q[req_idx] <= dirty_q[req_idx] | hit_vec;
            end else begin
              state_q <= victim_dirty ? ST_WB : ST_FILL;
            end
          end
        end
        ST_WB:     if (mem.req_ready) state_q <= ST_FILL;
        ST_FILL: begin
          if (mem.req_valid && mem.req_ready) fill_sent_q <= 1'b1;
          if (fill_write) begin
            dirty_q[req_idx] <= (dirty_q[req_idx] & ~victim_way) | (we_q ? victim_way : '0);
            state_q          <= ST_UPDATE;
          end
        end
        ST_UPDATE: state_q <= ST_RESP;
        ST_RESP:   if (res_ready_i) state_q <= ST_IDLE;
        default:   state_q <= ST_IDLE;
      endcase
    end
  end

  // Request and response payload
  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      addr_q  <= req_addr_i;
      we_q    <= req_we_i;
      size_q  <= req_size_i;
      wdata_q <= req_wdata_i;
    end
    if (fill_write) line_q <= mem.rsp_rdata;
    // Writes answer with zero data
    if (lk_done || (state_q == ST_UPDATE)) begin
      res_rdata_q <= we_q ? '0 : resp_line[addr_q[OFF_W-1:2]*XLEN +: XLEN];
    end
  end

endmodule

/* l2_mem_if.sv */
// Line request and response channel between the cache controller and the
// write-back buffer. Requests are whole-line fills or whole-line writes.

`timescale 1ns/1ps

interface l2_mem_if #(
  parameter int BLK_SIZE = l2_pkg::BLK_SIZE
);

  logic                    req_valid;
  logic                    req_ready;
  logic                    req_we;
  logic [l2_pkg::XLEN-1:0] req_addr;
  logic [BLK_SIZE-1:0]     req_wdata;
  logic                    rsp_valid;
  logic [BLK_SIZE-1:0]     rsp_rdata;

  // Controller side
  modport ctrl (
    output req_valid, req_we, req_addr, req_wdata,
    input  req_ready, rsp_valid, rsp_rdata
  );

  // Buffer side
  modport wbuf (
    input  req_valid, req_we, req_addr, req_wdata,
    output req_ready, rsp_valid, rsp_rdata
  );

endinterface

/* l2_pkg.sv */
// Shared definitions for the L2 cache
// Holds the geometry defaults used by the top level and the requester access width.
// Modules refer to these by scoped names and take the geometry as parameters.

package l2_pkg;

  // Geometry defaults
  parameter int XLEN       = 32;
  parameter int BLK_SIZE   = 128;
  parameter int CACHE_SIZE = 1024;
  parameter int NUM_WAY    = 4;

  // Width of a requester access
  typedef enum logic [1:0] {
    SZ_BYTE = 2'd0,
    SZ_HALF = 2'd1,
    SZ_WORD = 2'd2
  } access_size_e;

endpackage

/* l2_top.sv */
// L2 cache top level
// Requester port for single word, half-word and byte accesses, memory port for
// whole-line fills and write-backs. Geometry is set by the parameters below.

`timescale 1ns/1ps

module l2_top #(
  parameter int CACHE_SIZE = l2_pkg::CACHE_SIZE,
  parameter int BLK_SIZE   = l2_pkg::BLK_SIZE,
  parameter int XLEN       = l2_pkg::XLEN,
  parameter int NUM_WAY    = l2_pkg::NUM_WAY
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  // Requester side
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  logic [XLEN-1:0]      req_addr_i,
  input  logic                 req_we_i,
  input  l2_pkg::access_size_e req_size_i,
  input  logic [XLEN-1:0]      req_wdata_i,
  output logic                 res_valid_o,
  input  logic                 res_ready_i,
  output logic [XLEN-1:0]      res_rdata_o,
  // Memory side
  output logic                 mem_req_valid_o,
  input  logic                 mem_req_ready_i,
  output logic                 mem_req_we_o,
  output logic [XLEN-1:0]      mem_req_addr_o,
  output logic [BLK_SIZE-1:0]  mem_req_wdata_o,
  input  logic                 mem_res_valid_i,
  input  logic [BLK_SIZE-1:0]  mem_res_rdata_i
);

  l2_mem_if #(.BLK_SIZE(BLK_SIZE)) mem_if ();

  l2_cache #(
    .CACHE_SIZE  (CACHE_SIZE),
    .BLK_SIZE    (BLK_SIZE),
    .XLEN        (XLEN),
    .NUM_WAY     (NUM_WAY)
  ) u_cache (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_addr_i  (req_addr_i),
    .req_we_i    (req_we_i),
    .req_size_i  (req_size_i),
    .req_wdata_i (req_wdata_i),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i),
    .res_rdata_o (res_rdata_o),
    .mem         (mem_if.ctrl)
  );

  wb_buffer #(
    .BLK_SIZE        (BLK_SIZE)
  ) u_wb (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .mem             (mem_if.wbuf),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_we_o    (mem_req_we_o),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_req_wdata_o (mem_req_wdata_o),
    .mem_res_valid_i (mem_res_valid_i),
    .mem_res_rdata_i (mem_res_rdata_i)
  );

endmodule

/* plru_tree.sv */
// Tree pseudo-LRU state, NUM_WAY-1 bits per set
// A zero bit sends the victim search to the lower half, a one to the upper half.
// Touching a way points every bit on its path away from it.

`timescale 1ns/1ps

module plru_tree #(
  parameter int  NUM_WAY = 4,
  parameter int  NUM_SET = 16,
  localparam int IDX_W   = (NUM_SET > 1) ? $clog2(NUM_SET) : 1,
  localparam int LVL     = $clog2(NUM_WAY)
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic [IDX_W-1:0]   idx_i,
  input  logic               touch_i,
  input  logic [NUM_WAY-1:0] touch_way_i,
  input  logic               clear_i,
  output logic [NUM_WAY-1:0] victim_way_o
);

  logic [NUM_WAY-2:0] tree_q [NUM_SET];
  logic [NUM_WAY-2:0] tree_cur;
  logic [NUM_WAY-2:0] tree_upd;
  logic [LVL-1:0]     touch_idx;

  assign tree_cur = tree_q[idx_i];

  // Follow the bits from the root down to a leaf
  always_comb begin
    int node;
    int way;
    node = 0;
    way  = 0;
    for (int l = 0; l < LVL; l++) begin
      way  = way * 2 + int'(tree_cur[node]);
      node = node * 2 + 1 + int'(tree_cur[node]);
    end
    victim_way_o      = '0;
    victim_way_o[way] = 1'b1;
  end

  // Path update for the touched way
  always_comb begin
    int   node;
    logic dir;
    touch_idx = '0;
    for (int w = 0; w < NUM_WAY; w++) begin
      if (touch_way_i[w]) touch_idx = LVL'(w);
    end
    tree_upd = tree_cur;
    node     = 0;
    for (int l = 0; l < LVL; l++) begin
      dir            = touch_idx[LVL-1-l];
      tree_upd[node] = ~dir;
      node           = node * 2 + 1 + int'(dir);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int s = 0; s < NUM_SET; s++) tree_q[s] <= '0;
    end else if (clear_i) begin
      tree_q[idx_i] <= '0;
    end else if (touch_i) begin
      tree_q[idx_i] <= tree_upd;
    end
  end

endmodule

/* sp_bram.sv */
// Single-port synchronous array with a registered read
// Used for both line data and tag entries, selected by the entry type.
// Read data appears the cycle after the address and shows the old content on a write.

`timescale 1ns/1ps

module sp_bram #(
  parameter type entry_t = logic,
  parameter int  DEPTH   = 16,
  localparam int AW      = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  logic    clk_i,
  input  logic    [AW-1:0] addr_i,
  input  logic    we_i,
  input  entry_t  wdata_i,
  output entry_t  rdata_o
);

  entry_t mem [DEPTH];

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem[addr_i] <= wdata_i;
    end
    rdata_o <= mem[addr_i];
  end

endmodule

/* tb_l2_top.sv */
// Testbench for the L2 cache top level
// Models main memory with random ready and fill delay, keeps a scoreboard of the
// expected memory image and checks both ports with assertions. Compile with files.f.

`timescale 1ns/1ps

module tb_l2_top;

  localparam int NW        = l2_pkg::NUM_WAY;
  localparam int WPL       = l2_pkg::BLK_SIZE / 32;
  localparam int NUM_SET   = l2_pkg::CACHE_SIZE / (l2_pkg::BLK_SIZE / 8) / NW;
  localparam int MEM_WORDS = 4096;
  localparam int N_RANDOM  = 300;
  // 200 cycles of 4 ns per transaction
  localparam int TIMEOUT   = (N_RANDOM + 30) * 200 * 4;

  logic                        clk_i = 1'b0;
  logic                        rst_ni;
  logic                        flush_i;
  logic                        req_valid_i;
  logic                        req_ready_o;
  logic [31:0]                 req_addr_i;
  logic                        req_we_i;
  l2_pkg::access_size_e        req_size_i;
  logic [31:0]                 req_wdata_i;
  logic                        res_valid_o;
  logic                        res_ready_i;
  logic [31:0]                 res_rdata_o;
  logic                        mem_req_valid_o;
  logic                        mem_req_ready_i = 1'b0;
  logic                        mem_req_we_o;
  logic [31:0]                 mem_req_addr_o;
  logic [l2_pkg::BLK_SIZE-1:0] mem_req_wdata_o;
  logic                        mem_res_valid_i = 1'b0;
  logic [l2_pkg::BLK_SIZE-1:0] mem_res_rdata_i = '0;

  int   seed = 99;
  int   errors = 0;
  int   checks = 0;
  bit   bp_en = 1'b0;
  logic started = 1'b0;

  // Memory model state and its record of transfers
  logic [31:0]                 mem_words [MEM_WORDS];
  logic [31:0]                 ref_words [MEM_WORDS];
  int                          fill_wait = 0;
  int                          xfer_seq = 0;
  int                          wb_total = 0;
  int                          fill_total = 0;
  int                          wb_seq;
  int                          fill_seq;
  logic [31:0]                 wb_addr;
  logic [31:0]                 fill_addr;
  logic [l2_pkg::BLK_SIZE-1:0] wb_data;

  l2_top u_dut (.*);

  always #2 clk_i = ~clk_i;

  function automatic logic [31:0] rule_word(input int i);
    return 32'(i * 4) ^ 32'hA5A50000;
  endfunction

  // Whole line around addr, from memory or from the scoreboard
  function automatic logic [l2_pkg::BLK_SIZE-1:0] line_image(input bit from_ref,
                                                            input logic [31:0] addr);
    logic [l2_pkg::BLK_SIZE-1:0] l;
    int                          base;
    base = (int'(addr[13:2]) / WPL) * WPL;
    for (int i = 0; i < WPL; i++) begin
      l[32*i +: 32] = from_ref ? ref_words[base + i] : mem_words[base + i];
    end
    return l;
  endfunction

  // Heap layout, children of node n sit at 2n+1 and 2n+2
  function automatic int pick_victim(input logic [NW-2:0] t);
    int node;
    node = 0;
    while (node < NW - 1) node = 2 * node + 1 + int'(t[node]);
    return node - (NW - 1);
  endfunction

  function automatic logic [NW-2:0] touch_way(input logic [NW-2:0] t, input int way);
    int node;
    int parent;
    node = way + NW - 1;
    while (node > 0) begin
      parent    = (node - 1) / 2;
      // Parent points at the sibling
      t[parent] = (node == 2 * parent + 1);
      node      = parent;
    end
    return t;
  endfunction

  // ====================
  // Memory model
  // ====================

  always @(posedge clk_i) begin
    mem_res_valid_i <= 1'b0;
    if (!rst_ni) begin
      mem_req_ready_i <= 1'b0;
      fill_wait = 0;
      for (int i = 0; i < MEM_WORDS; i++) mem_words[i] = rule_word(i);
    end else begin
      mem_req_ready_i <= 1'(($random(seed) & 3) != 0);
      if (mem_req_valid_o && mem_req_ready_i) begin
        xfer_seq++;
        if (mem_req_we_o) begin
          wb_total++;
          wb_seq  = xfer_seq;
          wb_addr = mem_req_addr_o;
          wb_data = mem_req_wdata_o;
          for (int i = 0; i < WPL; i++) begin
            mem_words[(int'(wb_addr[13:2]) / WPL) * WPL + i] = wb_data[32*i +: 32];
          end
        end else begin
          fill_total++;
          fill_seq  = xfer_seq;
          fill_addr = mem_req_addr_o;
          fill_wait = 1 + ($random(seed) & 3);
        end
      end else if (fill_wait > 0) begin
        fill_wait--;
        if (fill_wait == 0) begin
          mem_res_valid_i <= 1'b1;
          mem_res_rdata_i <= line_image(1'b0, fill_addr);
        end
      end
    end
  end

  // ====================
  // Protocol assertions
  // ====================

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !started |-> !res_valid_o && !mem_req_valid_o)
  else begin
    errors++;
    $display("Error: response or memory request before the first request");
  end

  // Response holds while the requester stalls
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_rdata_o))
  else begin
    errors++;
    $display("Error: res_valid_o dropped or res_rdata_o changed under back-pressure");
  end

  // All request fields hold until memory takes the request
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_addr_o)
      && $stable(mem_req_we_o) && $stable(mem_req_wdata_o))
  else begin
    errors++;
    $display("Error: memory request changed before it was accepted");
  end

  task automatic expect_eq(input string name, input logic [127:0] got,
                           input logic [127:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("Error: %s", what);
    end
  endtask

  task automatic merge_write(input logic [31:0] addr, input l2_pkg::access_size_e sz,
                             input logic [31:0] data);
    int wi;
    wi = int'(addr[13:2]);
    case (sz)
      l2_pkg::SZ_BYTE: ref_words[wi][{addr[1:0], 3'b000} +: 8] = data[7:0];
      l2_pkg::SZ_HALF: ref_words[wi][{addr[1], 4'b0000} +: 16] = data[15:0];
      default:         ref_words[wi] = data;
    endcase
  endtask

  // One request and its response, lat counts edges from acceptance to res_valid_o
  task automatic run_access(input logic we, input logic [31:0] addr,
                            input l2_pkg::access_size_e sz, input logic [31:0] wdata,
                            output logic [31:0] rdata, output int lat);
    lat = 0;
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_we_i    <= we;
    req_addr_i  <= addr;
    req_size_i  <= sz;
    req_wdata_i <= wdata;
    started     <= 1'b1;
    @(negedge clk_i);
    while (!req_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    forever begin
      @(negedge clk_i);
      if (!res_valid_o) lat++;
      if (res_valid_o && res_ready_i) break;
      @(posedge clk_i);
      if (bp_en) res_ready_i <= 1'(($random(seed) & 3) != 0);
    end
    rdata = res_rdata_o;
    @(posedge clk_i);
    res_ready_i <= bp_en ? 1'($random(seed) & 1) : 1'b1;
  endtask

  task automatic write_access(input logic [31:0] addr, input l2_pkg::access_size_e sz,
                              input logic [31:0] data);
    logic [31:0] rd;
    int          lat;
    run_access(1'b1, addr, sz, data, rd, lat);
    merge_write(addr, sz, data);
    expect_eq("res_rdata_o", rd, '0);
  endtask

  task automatic read_check(input logic [31:0] addr, output logic [31:0] rd,
                            output int lat);
    run_access(1'b0, addr, l2_pkg::SZ_WORD, '0, rd, lat);
    expect_eq("res_rdata_o", rd, ref_words[int'(addr[13:2])]);
  endtask

  // Counts cycles with req_ready_o low, the walk needs one per set
  task automatic wait_walk();
    int n;
    n = 0;
    @(negedge clk_i);
    while (!req_ready_o) begin
      n++;
      @(negedge clk_i);
    end
    expect_true(n >= NUM_SET, "req_ready_o rose before the flush walk completed");
  endtask

  initial begin
    #(TIMEOUT);
    $display("Timeout after %0d ns, the DUT stopped responding", TIMEOUT);
    $display("Verification failed");
    $finish;
  end

  initial begin
    logic [31:0]   rd;
    logic [31:0]   addr;
    logic [31:0]   r;
    logic [31:0]   way_addr [NW];
    logic [31:0]   exp_wb_addr;
    logic [NW-2:0] tree;
    l2_pkg::access_size_e sz;
    int            lat;
    int            v;
    int            fills0;
    int            wbs0;

    rst_ni      = 1'b0;
    flush_i     = 1'b0;
    req_valid_i = 1'b0;
    req_addr_i  = '0;
    req_we_i    = 1'b0;
    req_size_i  = l2_pkg::SZ_WORD;
    req_wdata_i = '0;
    res_ready_i = 1'b1;
    for (int i = 0; i < MEM_WORDS; i++) ref_words[i] = rule_word(i);
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    wait_walk();

    // Read miss, then the same word as a hit
    fills0 = fill_total;
    wbs0   = wb_total;
    read_check(32'h0000_0124, rd, lat);
    expect_eq("fill count", fill_total - fills0, 1);
    expect_eq("mem_req_addr_o", fill_addr, 32'h0000_0120);
    read_check(32'h0000_0124, rd, lat);
    expect_eq("hit latency", lat, 2);
    expect_eq("memory requests", fill_total + wb_total - fills0 - wbs0, 1);

    // Sub-word merges in one line
    write_access(32'h0000_0130, l2_pkg::SZ_WORD, 32'h1122_3344);
    write_access(32'h0000_0135, l2_pkg::SZ_BYTE, 32'h0000_00AB);
    write_access(32'h0000_013A, l2_pkg::SZ_HALF, 32'h0000_BEEF);
    write_access(32'h0000_0131, l2_pkg::SZ_BYTE, 32'h0000_0077);
    for (int k = 0; k < 4; k++) read_check(32'h0000_0130 + 32'(4 * k), rd, lat);

    // One more line than ways into a single set
    tree = '0;
    wbs0 = wb_total;
    exp_wb_addr = '0;
    for (int k = 0; k <= NW; k++) begin
      addr = 32'h0000_2050 + 32'(k * 256);
      v    = pick_victim(tree);
      if (k == NW) exp_wb_addr = way_addr[v];
      way_addr[v] = addr;
      tree = touch_way(tree, v);
      write_access(addr, l2_pkg::SZ_WORD, 32'hC0DE_0000 | 32'(k));
    end
    expect_eq("write-back count", wb_total - wbs0, 1);
    expect_eq("mem_req_addr_o", wb_addr, exp_wb_addr);
    expect_eq("mem_req_wdata_o", wb_data, line_image(1'b1, exp_wb_addr));
    expect_true(wb_seq < fill_seq, "write-back did not precede the fill");

    // Flush drops dirty lines, memory content returns
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    wait_walk();
    for (int i = 0; i < MEM_WORDS; i++) ref_words[i] = mem_words[i];
    fills0 = fill_total;
    read_check(32'h0000_0134, rd, lat);
    expect_eq("fill count", fill_total - fills0, 1);
    expect_eq("res_rdata_o", rd, rule_word(32'h134 / 4));

    // Random mix under back-pressure
    bp_en = 1'b1;
    for (int n = 0; n < N_RANDOM; n++) begin
      r    = $random(seed);
      addr = {20'h0, r[11:0]};
      sz   = l2_pkg::access_size_e'($unsigned($random(seed)) % 3);
      if (sz == l2_pkg::SZ_HALF) addr[0] = 1'b0;
      if (sz == l2_pkg::SZ_WORD) addr[1:0] = 2'b00;
      if (r[31]) begin
        write_access(addr, sz, $random(seed));
      end else begin
        read_check(addr, rd, lat);
      end
    end

    repeat (4) @(posedge clk_i);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* wb_buffer.sv */
// One-entry buffer between the cache controller and main memory
// Takes a line write or a line fill from the controller and presents it to memory
// until accepted. Fill data is passed back to the controller as a one-cycle response.

`timescale 1ns/1ps

module wb_buffer #(
  parameter int BLK_SIZE = l2_pkg::BLK_SIZE
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  l2_mem_if.wbuf                  mem,
  output logic                    mem_req_valid_o,
  input  logic                    mem_req_ready_i,
  output logic                    mem_req_we_o,
  output logic [l2_pkg::XLEN-1:0] mem_req_addr_o,
  output logic [BLK_SIZE-1:0]     mem_req_wdata_o,
  input  logic                    mem_res_valid_i,
  input  logic [BLK_SIZE-1:0]     mem_res_rdata_i
);

  typedef enum logic [1:0] {
    BUF_EMPTY,
    BUF_SEND,
    BUF_WAIT
  } buf_state_e;

  buf_state_e              state_q;
  logic                    we_q;
  logic [l2_pkg::XLEN-1:0] addr_q;
  logic [BLK_SIZE-1:0]     wdata_q;

  // Controller side
  assign mem.req_ready = (state_q == BUF_EMPTY);
  assign mem.rsp_valid = (state_q == BUF_WAIT) && mem_res_valid_i;
  assign mem.rsp_rdata = mem_res_rdata_i;

  // Memory side
  assign mem_req_valid_o = (state_q == BUF_SEND);
  assign mem_req_we_o    = we_q;
  assign mem_req_addr_o  = addr_q;
  assign mem_req_wdata_o = wdata_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= BUF_EMPTY;
    end else begin
      case (state_q)
        BUF_EMPTY: if (mem.req_valid) state_q <= BUF_SEND;
        BUF_SEND: begin
          // Writes are done once memory takes them
          if (mem_req_ready_i) state_q <= we_q ? BUF_EMPTY : BUF_WAIT;
        end
        BUF_WAIT:  if (mem_res_valid_i) state_q <= BUF_EMPTY;
        default:   state_q <= BUF_EMPTY;
      endcase
    end
  end

  // Request capture
  always_ff @(posedge clk_i) begin
    if ((state_q == BUF_EMPTY) && mem.req_valid) begin
      we_q    <= mem.req_we;
      addr_q  <= mem.req_addr;
      wdata_q <= mem.req_wdata;
    end
  end

endmodule
